// ==== Makefile ====
# Verilator build and run for the adaptive-threshold binarizer.

VERILATOR ?= verilator
TOP       ?= thresh_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass message appears as a line of its own.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
rtl/thresh_pkg.sv
rtl/line_window.sv
rtl/window_sum.sv
rtl/sum_sequencer.sv
rtl/adaptive_threshold.sv
rtl/thresh_top.sv
testbench/thresh_props.sv
testbench/thresh_tb.sv

// ==== rtl/adaptive_threshold.sv ====
`timescale 1ns/1ps

module adaptive_threshold (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_valid,
    input  logic                         i_qual,
    input  thresh_pkg::sum_out_t         i_sum,
    output logic                         o_valid,
    output logic                         o_bin,
    output logic [thresh_pkg::ACC_W-1:0] o_sum,
    output logic [thresh_pkg::PIX_W-1:0] o_center
);

    localparam int ACC_W = thresh_pkg::ACC_W;

    logic [ACC_W-1:0] scaled;
    logic             take;

    // centre weighted like the running sum.
    assign scaled = ACC_W'(i_sum.center) * ACC_W'(thresh_pkg::WIN_SCALE);
    assign take   = i_valid & i_qual;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid  <= 1'b0;
            o_bin    <= 1'b0;
            o_sum    <= '0;
            o_center <= '0;
        end else begin
            o_valid <= take;
            if (take) begin
                o_bin    <= (scaled > i_sum.run_sum);
                o_sum    <= i_sum.run_sum;
                o_center <= i_sum.center;
            end
        end
    end

endmodule

// ==== rtl/line_window.sv ====
`timescale 1ns/1ps

module line_window #(
    parameter int COLS = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_valid,
    input  logic [thresh_pkg::PIX_W-1:0]   i_pixel,
    output thresh_pkg::pix_win_t           o_win
);

    localparam int PIX_W = thresh_pkg::PIX_W;
    localparam int AW    = $clog2(COLS);

    logic [PIX_W-1:0] line1 [COLS];
    logic [PIX_W-1:0] line2 [COLS];
    logic [AW-1:0]    ptr;
    logic [PIX_W-1:0] line1_q;
    logic [PIX_W-1:0] line2_q;
    thresh_pkg::pix_win_t win;

    // one line back and two lines back, same column.
    assign line1_q = line1[ptr];
    assign line2_q = line2[ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (i_valid) begin
            if (ptr == AW'(COLS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // the older line is fed from the newer one.
    always_ff @(posedge clk) begin
        if (i_valid) begin
            line1[ptr] <= i_pixel;
            line2[ptr] <= line1_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win <= '0;
        end else if (i_valid) begin
            win.p00 <= win.p01;
            win.p01 <= win.p02;
            win.p02 <= line2_q;
            win.p10 <= win.p11;
            win.p11 <= win.p12;
            win.p12 <= line1_q;
            win.p20 <= win.p21;
            win.p21 <= win.p22;
            win.p22 <= i_pixel;
        end
    end

    assign o_win = win;

endmodule

// ==== rtl/sum_sequencer.sv ====
`timescale 1ns/1ps

module sum_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_valid,
    input  thresh_pkg::pos_flags_t i_pos,
    output thresh_pkg::acc_ctrl_t  o_ctrl,
    output logic                   o_qual
);

    localparam int DEPTH = thresh_pkg::PIPE_DEPTH;
    // stage whose flags line up with the accumulator update.
    localparam int ACC_IDX = DEPTH - 2;

    thresh_pkg::pos_flags_t pos_d [DEPTH];

    // pos_d[j] holds the flags of the pixel accepted j+1 strobes ago.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                pos_d[i] <= '0;
            end
        end else if (i_valid) begin
            pos_d[0] <= i_pos;
            for (int i = 1; i < DEPTH; i++) begin
                pos_d[i] <= pos_d[i-1];
            end
        end
    end

    // the running sum restarts at the first full window of each row.
    assign o_ctrl.load = pos_d[ACC_IDX].col_first;

    // column 11 or more.
    // column is at least 10 here and one strobe back, which only holds
    // inside a row.
    assign o_ctrl.sub = pos_d[ACC_IDX].col_full & pos_d[ACC_IDX+1].col_full;

    assign o_qual = pos_d[DEPTH-1].row_ok & pos_d[DEPTH-1].col_full;

endmodule

// ==== rtl/thresh_pkg.sv ====
package thresh_pkg;

    // data widths.
    localparam int PIX_W  = 8;
    localparam int WSUM_W = 12;
    localparam int ACC_W  = 15;

    // nine 3x3 sums make up one running sum.
    localparam int HIST_LEN = 9;

    // accepted pixels from a window's newest pixel to its registered result.
    localparam int PIPE_DEPTH = 4;

    // total weight of the running sum, nine sums of nine pixels.
    localparam int WIN_SCALE = 81;

    // row 0 is the oldest line, column 2 the newest column.
    typedef struct packed {
        logic [PIX_W-1:0] p00, p01, p02;
        logic [PIX_W-1:0] p10, p11, p12;
        logic [PIX_W-1:0] p20, p21, p22;
    } pix_win_t;

    typedef struct packed {
        logic row_ok;
        logic col_first;
        logic col_full;
    } pos_flags_t;

    typedef struct packed {
        logic load;
        logic sub;
    } acc_ctrl_t;

    typedef struct packed {
        logic [ACC_W-1:0] run_sum;
        logic [PIX_W-1:0] center;
    } sum_out_t;

endpackage

// ==== rtl/thresh_top.sv ====
`timescale 1ns/1ps

module thresh_top #(
    parameter int COLS = 16,
    parameter int ROWS = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_valid,
    input  logic [thresh_pkg::PIX_W-1:0] i_pixel,
    output logic                         o_valid,
    output logic                         o_bin,
    output logic [thresh_pkg::ACC_W-1:0] o_sum,
    output logic [thresh_pkg::PIX_W-1:0] o_center
);

    thresh_pkg::pix_win_t   win;
    thresh_pkg::pos_flags_t pos;
    thresh_pkg::acc_ctrl_t  ctrl;
    thresh_pkg::sum_out_t   sums;
    logic                   qual;

    line_window #(.COLS(COLS)) line_window_i (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_pixel(i_pixel), .o_win(win)
    );

    window_sum #(.COLS(COLS), .ROWS(ROWS)) window_sum_i (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_win(win), .i_ctrl(ctrl),
        .o_pos(pos), .o_sum(sums)
    );

    sum_sequencer sum_sequencer_i (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_pos(pos),
        .o_ctrl(ctrl), .o_qual(qual)
    );

    adaptive_threshold adaptive_threshold_i (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_qual(qual), .i_sum(sums),
        .o_valid(o_valid), .o_bin(o_bin), .o_sum(o_sum), .o_center(o_center)
    );

endmodule

// ==== rtl/window_sum.sv ====
`timescale 1ns/1ps

module window_sum #(
    parameter int COLS = 16,
    parameter int ROWS = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_valid,
    input  thresh_pkg::pix_win_t   i_win,
    input  thresh_pkg::acc_ctrl_t  i_ctrl,
    output thresh_pkg::pos_flags_t o_pos,
    output thresh_pkg::sum_out_t   o_sum
);

    localparam int PIX_W    = thresh_pkg::PIX_W;
    localparam int WSUM_W   = thresh_pkg::WSUM_W;
    localparam int ACC_W    = thresh_pkg::ACC_W;
    localparam int HIST_LEN = thresh_pkg::HIST_LEN;
    localparam int ROW_W    = PIX_W + 2;
    localparam int CW       = $clog2(COLS);
    localparam int RW       = $clog2(ROWS);
    // first column with a full 3x3 window, and first with nine of them.
    localparam int COL_FIRST = 2;
    localparam int COL_FULL  = COL_FIRST + HIST_LEN - 1;
    localparam int ROW_OK    = 2;
    // stages from the input register to the accumulator.
    localparam int CTR_DLY   = thresh_pkg::PIPE_DEPTH - 2;

    logic [CW-1:0]        col_cnt;
    logic [RW-1:0]        row_cnt;
    thresh_pkg::pix_win_t win_q;
    logic [ROW_W-1:0]     row_sum [3];
    logic [WSUM_W-1:0]    sum3x3;
    logic [WSUM_W-1:0]    hist [HIST_LEN];
    logic [ACC_W-1:0]     acc;
    logic [ACC_W-1:0]     acc_next;
    logic [PIX_W-1:0]     ctr_d [CTR_DLY];

    function automatic logic [ROW_W-1:0] add3(input logic [PIX_W-1:0] a,
                                              input logic [PIX_W-1:0] b,
                                              input logic [PIX_W-1:0] c);
        return ROW_W'(a) + ROW_W'(b) + ROW_W'(c);
    endfunction

    // counters hold the position of the pixel being accepted.
    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_valid) begin
            if (col_cnt == CW'(COLS - 1)) begin
                col_cnt <= '0;
                row_cnt <= (row_cnt == RW'(ROWS - 1)) ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    assign o_pos.row_ok    = (row_cnt >= RW'(ROW_OK));
    assign o_pos.col_first = (col_cnt == CW'(COL_FIRST));
    assign o_pos.col_full  = (col_cnt >= CW'(COL_FULL));

    // input register, then one level of row sums.
    always_ff @(posedge clk) begin
        if (rst) begin
            win_q <= '0;
            for (int i = 0; i < 3; i++) begin
                row_sum[i] <= '0;
            end
        end else if (i_valid) begin
            win_q      <= i_win;
            row_sum[0] <= add3(win_q.p00, win_q.p01, win_q.p02);
            row_sum[1] <= add3(win_q.p10, win_q.p11, win_q.p12);
            row_sum[2] <= add3(win_q.p20, win_q.p21, win_q.p22);
        end
    end

    assign sum3x3 = WSUM_W'(row_sum[0]) + WSUM_W'(row_sum[1]) + WSUM_W'(row_sum[2]);

    // hist[HIST_LEN-1] is the sum from nine positions back.
    always_comb begin
        if (i_ctrl.load) begin
            acc_next = ACC_W'(sum3x3);
        end else if (i_ctrl.sub) begin
            acc_next = acc + ACC_W'(sum3x3) - ACC_W'(hist[HIST_LEN-1]);
        end else begin
            acc_next = acc + ACC_W'(sum3x3);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            for (int i = 0; i < HIST_LEN; i++) begin
                hist[i] <= '0;
            end
            for (int i = 0; i < CTR_DLY; i++) begin
                ctr_d[i] <= '0;
            end
        end else if (i_valid) begin
            acc     <= acc_next;
            hist[0] <= sum3x3;
            for (int i = 1; i < HIST_LEN; i++) begin
                hist[i] <= hist[i-1];
            end
            ctr_d[0] <= win_q.p11;
            for (int i = 1; i < CTR_DLY; i++) begin
                ctr_d[i] <= ctr_d[i-1];
            end
        end
    end

    assign o_sum.run_sum = acc;
    assign o_sum.center  = ctr_d[CTR_DLY-1];

endmodule

// ==== testbench/thresh_props.sv ====
`timescale 1ns/1ps

module thresh_props (
    input logic                         clk,
    input logic                         rst,
    input logic                         i_valid,
    input logic                         o_valid,
    input logic [thresh_pkg::ACC_W-1:0] o_sum,
    input logic [thresh_pkg::PIX_W-1:0] o_center
);

    // a result only follows an accepted pixel.
    a_valid_needs_strobe: assert property (
        @(posedge clk) disable iff (rst)
        !i_valid |=> !o_valid
    ) else $error("o_valid high without a pixel strobe in the cycle before");

    // reset clears the output strobe.
    a_quiet_in_reset: assert property (
        @(posedge clk)
        rst |=> !o_valid
    ) else $error("o_valid high in the cycle after reset was asserted");

    // data outputs hold between results.
    a_outputs_hold: assert property (
        @(posedge clk) disable iff (rst)
        !o_valid |-> ($stable(o_sum) && $stable(o_center))
    ) else $error("o_sum or o_center changed without o_valid");

endmodule

bind thresh_top thresh_props thresh_props_i (
    .clk(clk),
    .rst(rst),
    .i_valid(i_valid),
    .o_valid(o_valid),
    .o_sum(o_sum),
    .o_center(o_center)
);

// ==== testbench/thresh_tb.sv ====
`timescale 1ns/1ps

module thresh_tb;

    localparam int COLS      = 16;
    localparam int ROWS      = 8;
    localparam int PIX_W     = thresh_pkg::PIX_W;
    localparam int ACC_W     = thresh_pkg::ACC_W;
    localparam int FRAME     = COLS * ROWS;
    // five rows and most of the next, so a result is due when reset comes.
    localparam int PART_PIX  = 5 * COLS + 14;
    localparam int FIRST_COL = 10;
    localparam int FIRST_ROW = 2;
    localparam int WEIGHT    = 81;
    localparam int MAX_GAP   = 3;
    localparam int PER_FRAME = (COLS - FIRST_COL) * (ROWS - FIRST_ROW);
    localparam int N_RESULTS = 4 * PER_FRAME + 3 * (COLS - FIRST_COL);
    localparam int N_STROBES = 4 * FRAME + PART_PIX + thresh_pkg::PIPE_DEPTH;
    localparam int WDOG_CYC  = N_STROBES * (MAX_GAP + 1) + 100;

    logic             clk;
    logic             rst;
    logic             i_valid;
    logic [PIX_W-1:0] i_pixel;
    logic             o_valid;
    logic             o_bin;
    logic [ACC_W-1:0] o_sum;
    logic [PIX_W-1:0] o_center;

    logic [31:0]      rng;
    logic [PIX_W-1:0] src [FRAME];
    int               img [ROWS][COLS];
    int               tr;
    int               tc;
    int               n_seen;
    string            cur_test;
    logic [ACC_W-1:0] exp_sum [$];
    logic [PIX_W-1:0] exp_ctr [$];
    string            exp_name [$];

    thresh_top #(.COLS(COLS), .ROWS(ROWS)) thresh_top_i (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_pixel(i_pixel),
        .o_valid(o_valid), .o_bin(o_bin), .o_sum(o_sum), .o_center(o_center)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // nine 3x3 sums ending at (tr, tc), each over rows tr-2 to tr.
    task automatic expect_window_result();
        int sum;
        sum = 0;
        for (int cc = tc - 8; cc <= tc; cc++) begin
            for (int rr = tr - 2; rr <= tr; rr++) begin
                for (int dc = cc - 2; dc <= cc; dc++) begin
                    sum += img[rr][dc];
                end
            end
        end
        exp_sum.push_back(ACC_W'(sum));
        exp_ctr.push_back(PIX_W'(img[tr-1][tc-1]));
        exp_name.push_back(cur_test);
    endtask

    task automatic send_pixel(input logic [PIX_W-1:0] pix, input int gap);
        i_valid = 1'b1;
        i_pixel = pix;
        img[tr][tc] = int'(pix);
        if (tr >= FIRST_ROW && tc >= FIRST_COL) begin
            expect_window_result();
        end
        if (tc == COLS - 1) begin
            tc = 0;
            tr = (tr == ROWS - 1) ? 0 : tr + 1;
        end else begin
            tc = tc + 1;
        end
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        // pixel bus keeps moving while idle.
        i_pixel = ~pix;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_pixels(input int npix, input int max_gap);
        int gap;
        for (int i = 0; i < npix; i++) begin
            gap = 0;
            if (max_gap > 0) begin
                rng = xorshift32(rng);
                gap = int'(rng % 32'(max_gap + 1));
            end
            send_pixel(src[i], gap);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < FRAME; i++) begin
            rng = xorshift32(rng);
            src[i] = rng[PIX_W-1:0];
        end
    endtask

    task automatic fill_grey(input logic [PIX_W-1:0] level);
        for (int i = 0; i < FRAME; i++) begin
            src[i] = level;
        end
    endtask

    // results still in flight are lost with the reset.
    task automatic apply_reset(input logic strobe);
        rst = 1'b1;
        // a pixel strobe that meets the first reset edge is dropped.
        i_valid = strobe;
        exp_sum.delete();
        exp_ctr.delete();
        exp_name.delete();
        repeat (4) begin
            @(posedge clk);
            #1;
            i_valid = 1'b0;
        end
        rst = 1'b0;
        tr = 0;
        tc = 0;
    endtask

    task automatic check_result();
        logic [ACC_W-1:0] e_sum;
        logic [PIX_W-1:0] e_ctr;
        logic             e_bin;
        string            name;
        assert (exp_sum.size() > 0)
            else stop_on_error("o_valid pulsed while no result was expected");
        e_sum = exp_sum.pop_front();
        e_ctr = exp_ctr.pop_front();
        name  = exp_name.pop_front();
        e_bin = (WEIGHT * int'(e_ctr)) > int'(e_sum);
        assert (o_sum === e_sum)
            else stop_on_error($sformatf("ERR %s o_sum expected %0d actual %0d",
                                         name, e_sum, o_sum));
        assert (o_center === e_ctr)
            else stop_on_error($sformatf("ERR %s o_center expected %0d actual %0d",
                                         name, e_ctr, o_center));
        assert (o_bin === e_bin)
            else stop_on_error($sformatf("ERR %s o_bin expected %0d actual %0d",
                                         name, e_bin, o_bin));
        n_seen++;
    endtask

    always @(negedge clk) begin
        if (!rst && o_valid) begin
            check_result();
        end
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        stop_on_error("watchdog expired before the test sequence finished");
    end

    initial begin
        rst      = 1'b1;
        i_valid  = 1'b0;
        i_pixel  = '0;
        rng      = 32'd19;
        tr       = 0;
        tc       = 0;
        n_seen   = 0;
        cur_test = "reset";
        apply_reset(1'b0);
        fill_random();
        cur_test = "frame_back_to_back";
        send_pixels(FRAME, 0);
        // same pixels again with idle cycles between strobes.
        cur_test = "frame_random_gaps";
        send_pixels(FRAME, MAX_GAP);
        fill_grey(8'd137);
        cur_test = "grey_frame";
        send_pixels(FRAME, MAX_GAP);
        fill_random();
        cur_test = "partial_frame";
        send_pixels(PART_PIX, MAX_GAP);
        apply_reset(1'b1);
        fill_random();
        cur_test = "frame_after_reset";
        send_pixels(FRAME, MAX_GAP);
        // padding on row 0 pushes the last results out.
        fill_grey(8'd0);
        cur_test = "padding";
        send_pixels(thresh_pkg::PIPE_DEPTH, 0);
        repeat (4) @(posedge clk);
        assert (exp_sum.size() == 0)
            else stop_on_error($sformatf("%0d expected results never appeared",
                                         exp_sum.size()));
        assert (n_seen == N_RESULTS)
            else stop_on_error($sformatf("ERR result_count expected %0d actual %0d",
                                         N_RESULTS, n_seen));
        $display("No errors");
        $finish;
    end

endmodule
